// ==== include/dhcp_consts.svh ====
`ifndef DHCP_CONSTS_SVH
`define DHCP_CONSTS_SVH

// bootp op codes
`define DHCP_OP_BOOTREQUEST 8'd1
`define DHCP_OP_BOOTREPLY   8'd2

// ethernet hardware type and address length
`define DHCP_HTYPE_ETH      8'd1
`define DHCP_HLEN_ETH       8'd6

// values of option 53
`define DHCP_MSG_DISCOVER   8'd1
`define DHCP_MSG_OFFER      8'd2
`define DHCP_MSG_REQUEST    8'd3

// option codes
`define DHCP_OPT_GATEWAY    8'd3
`define DHCP_OPT_REQ_IP     8'd50
`define DHCP_OPT_MSG_TYPE   8'd53
`define DHCP_OPT_SERVER_ID  8'd54
`define DHCP_OPT_END        8'd255

`define DHCP_COOKIE         32'h6382_5363
`define DHCP_COOKIE_LAST    8'hEF
`define DHCP_HEADER_LAST    8'hF2
// zero bytes after the end option
`define DHCP_END_PAD        8'd4
// mac, ip, gateway, mask
`define EEPROM_CFG_BYTES    5'd18

`endif

// ==== logic/dhcp_pkg.sv ====
`default_nettype none

package dhcp_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] xid_t;
    typedef logic [7:0]  msg_ptr_t;

    typedef enum logic [1:0] {
        ld_idle,
        ld_load,
        ld_done
    } loader_state_t;

    // one state per message section
    typedef enum logic [2:0] {
        bld_idle,
        bld_fixed,
        bld_opt3,
        bld_opt50,
        bld_opt54,
        bld_end,
        bld_done
    } builder_state_t;

    typedef enum logic [2:0] {
        prs_idle,
        prs_fixed,
        prs_opt_id,
        prs_opt_len,
        prs_opt_val,
        prs_drain,
        prs_done
    } parser_state_t;

endpackage

`default_nettype wire

// ==== logic/net_cfg_if.sv ====
`default_nettype none

// network parameters as loaded from the eeprom
interface net_cfg_if
    import dhcp_pkg::*;
();

    mac_addr_t local_mac;
    ip_addr_t  local_ip;
    ip_addr_t  gateway_ip;
    ip_addr_t  subnet_mask;

    modport loader (
        output local_mac,
        output local_ip,
        output gateway_ip,
        output subnet_mask
    );

    modport user (
        input local_mac,
        input local_ip,
        input gateway_ip,
        input subnet_mask
    );

endinterface

`default_nettype wire

// ==== logic/lease_if.sv ====
`default_nettype none

// offer results go to the builder, the xid goes back to the parser
interface lease_if
    import dhcp_pkg::*;
();

    ip_addr_t offered_ip;
    ip_addr_t gateway_ip;
    logic     gateway_valid;
    ip_addr_t server_id;
    logic     server_id_valid;
    xid_t     xid;

    modport parser (
        output offered_ip,
        output gateway_ip,
        output gateway_valid,
        output server_id,
        output server_id_valid,
        input  xid
    );

    modport builder (
        input  offered_ip,
        input  gateway_ip,
        input  gateway_valid,
        input  server_id,
        input  server_id_valid,
        output xid
    );

endinterface

`default_nettype wire

// ==== logic/eeprom_cfg_loader.sv ====
`default_nettype none

`include "dhcp_consts.svh"

module eeprom_cfg_loader
    import dhcp_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        eeprom_start,
    output logic       eeprom_finished,
    input  wire byte_t eeprom_data,
    input  wire        eeprom_valid,
    output logic       eeprom_ready,
    net_cfg_if.loader  cfg
);

    loader_state_t state;
    logic [4:0]    cnt;
    logic          xfer;

    assign xfer = eeprom_valid && eeprom_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state           <= ld_idle;
            cnt             <= '0;
            eeprom_ready    <= 1'b0;
            eeprom_finished <= 1'b0;
        end
        else
        begin
            case (state)
                ld_idle:
                begin
                    if (eeprom_start)
                    begin
                        cnt          <= '0;
                        eeprom_ready <= 1'b1;
                        state        <= ld_load;
                    end
                end
                ld_load:
                begin
                    if (xfer)
                    begin
                        cnt <= cnt + 5'd1;
                        if (cnt == `EEPROM_CFG_BYTES - 5'd1)
                        begin
                            eeprom_ready    <= 1'b0;
                            eeprom_finished <= 1'b1;
                            state           <= ld_done;
                        end
                    end
                end
                default:
                begin
                    if (!eeprom_start)
                    begin
                        eeprom_finished <= 1'b0;
                        state           <= ld_idle;
                    end
                end
            endcase
        end
    end

    // fields arrive msb first in the order mac, ip, gateway, mask
    always_ff @(posedge clk)
    begin
        if (xfer)
        begin
            if (cnt < 5'd6)
                cfg.local_mac <= {cfg.local_mac[39:0], eeprom_data};
            else if (cnt < 5'd10)
                cfg.local_ip <= {cfg.local_ip[23:0], eeprom_data};
            else if (cnt < 5'd14)
                cfg.gateway_ip <= {cfg.gateway_ip[23:0], eeprom_data};
            else
                cfg.subnet_mask <= {cfg.subnet_mask[23:0], eeprom_data};
        end
    end

    a_no_ready_when_done: assert property (@(posedge clk) disable iff (rst)
        eeprom_finished |-> !eeprom_ready);

endmodule

`default_nettype wire

// ==== logic/offer_parser.sv ====
`default_nettype none

`include "dhcp_consts.svh"

module offer_parser
    import dhcp_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        offer_start,
    output logic       offer_finished,
    output logic       offer_received,
    input  wire byte_t offer_data,
    input  wire        offer_valid,
    output logic       offer_ready,
    input  wire        offer_last,
    lease_if.parser    lease
);

    parser_state_t state;
    msg_ptr_t      ptr;
    byte_t         opt_id;
    byte_t         opt_left;
    ip_addr_t      opt_data;
    byte_t         xid_byte;
    logic          hdr_bad;
    logic          xfer;

    assign xfer     = offer_valid && offer_ready;
    assign xid_byte = lease.xid[31 - 8 * ptr[1:0] -: 8];

    // header fields that must match our own request
    always_comb
    begin
        case (ptr) inside
            8'h00:          hdr_bad = offer_data != `DHCP_OP_BOOTREPLY;
            8'h01:          hdr_bad = offer_data != `DHCP_HTYPE_ETH;
            8'h02:          hdr_bad = offer_data != `DHCP_HLEN_ETH;
            [8'h04:8'h07]:  hdr_bad = offer_data != xid_byte;
            default:        hdr_bad = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state                 <= prs_idle;
            ptr                   <= '0;
            offer_ready           <= 1'b0;
            offer_finished        <= 1'b0;
            offer_received        <= 1'b0;
            lease.gateway_valid   <= 1'b0;
            lease.server_id_valid <= 1'b0;
        end
        else
        begin
            case (state)
                prs_idle:
                begin
                    if (offer_start)
                    begin
                        ptr                   <= '0;
                        offer_ready           <= 1'b1;
                        lease.gateway_valid   <= 1'b0;
                        lease.server_id_valid <= 1'b0;
                        state                 <= prs_fixed;
                    end
                end
                prs_fixed:
                begin
                    if (xfer)
                    begin
                        ptr <= ptr + 8'd1;
                        if (hdr_bad)
                            state <= prs_drain;
                        else if (ptr == `DHCP_COOKIE_LAST)
                            state <= prs_opt_id;
                    end
                end
                prs_opt_id:
                begin
                    if (xfer)
                        state <= (offer_data == `DHCP_OPT_END) ? prs_drain : prs_opt_len;
                end
                prs_opt_len:
                begin
                    if (xfer)
                        state <= (offer_data == 8'd0) ? prs_drain : prs_opt_val;
                end
                prs_opt_val:
                begin
                    if (xfer && opt_left == 8'd1)
                    begin
                        state <= prs_opt_id;
                        case (opt_id)
                            `DHCP_OPT_GATEWAY:   lease.gateway_valid <= 1'b1;
                            `DHCP_OPT_SERVER_ID: lease.server_id_valid <= 1'b1;
                            `DHCP_OPT_MSG_TYPE:  offer_received <= offer_data == `DHCP_MSG_OFFER;
                            default:             ;
                        endcase
                    end
                end
                prs_done:
                begin
                    if (!offer_start)
                    begin
                        offer_finished <= 1'b0;
                        state          <= prs_idle;
                    end
                end
                default:
                    ;
            endcase
            // tlast ends the frame in any state
            if (xfer && offer_last)
            begin
                offer_ready    <= 1'b0;
                offer_finished <= 1'b1;
                state          <= prs_done;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (xfer)
        begin
            case (state)
                prs_fixed:
                begin
                    if (ptr inside {[8'h10:8'h13]})
                        lease.offered_ip <= {lease.offered_ip[23:0], offer_data};
                end
                prs_opt_id:
                    opt_id <= offer_data;
                prs_opt_len:
                    opt_left <= offer_data;
                prs_opt_val:
                begin
                    opt_left <= opt_left - 8'd1;
                    opt_data <= {opt_data[23:0], offer_data};
                    // keep only the last four value bytes
                    if (opt_left == 8'd1 && opt_id == `DHCP_OPT_GATEWAY)
                        lease.gateway_ip <= {opt_data[23:0], offer_data};
                    if (opt_left == 8'd1 && opt_id == `DHCP_OPT_SERVER_ID)
                        lease.server_id <= {opt_data[23:0], offer_data};
                end
                default:
                    ;
            endcase
        end
    end

    a_finished_in_start: assert property (@(posedge clk) disable iff (rst)
        offer_finished |-> offer_start || $past(offer_start));

endmodule

`default_nettype wire

// ==== logic/discover_builder.sv ====
`default_nettype none

`include "dhcp_consts.svh"

module discover_builder
    import dhcp_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        discover_start,
    input  wire        discover_is_new,
    output logic       discover_finished,
    input  wire xid_t  xid_seed,
    output byte_t      msg_data,
    output logic       msg_valid,
    input  wire        msg_ready,
    output logic       msg_last,
    net_cfg_if.user    cfg,
    lease_if.builder   lease
);

    builder_state_t state;
    msg_ptr_t       ptr;
    msg_ptr_t       sec_last;
    byte_t          fixed_byte;
    ip_addr_t       req_ip;
    logic           is_new;
    logic           use_gw;
    logic           use_sid;
    logic           xfer;

    // byte of a big-endian field whose lsb sits at offset last
    function automatic byte_t pick(logic [47:0] word, msg_ptr_t last, msg_ptr_t idx);
        return byte_t'(word >> (8 * (last - idx)));
    endfunction

    // option with a four byte address value
    function automatic byte_t opt_byte(byte_t code, ip_addr_t value, msg_ptr_t idx);
        byte_t b;
        case (idx)
            8'd0:    b = code;
            8'd1:    b = 8'd4;
            default: b = pick(value, 8'd5, idx);
        endcase
        return b;
    endfunction

    assign msg_valid = (state != bld_idle) && (state != bld_done);
    assign xfer      = msg_valid && msg_ready;
    assign msg_last  = (state == bld_end) && (ptr == sec_last);

    always_comb
    begin
        case (state)
            bld_fixed: sec_last = `DHCP_HEADER_LAST;
            bld_end:   sec_last = `DHCP_END_PAD;
            default:   sec_last = 8'd5;
        endcase
    end

    always_comb
    begin
        case (ptr) inside
            8'h00:         fixed_byte = `DHCP_OP_BOOTREQUEST;
            8'h01:         fixed_byte = `DHCP_HTYPE_ETH;
            8'h02:         fixed_byte = `DHCP_HLEN_ETH;
            [8'h04:8'h07]: fixed_byte = pick(lease.xid, 8'h07, ptr);
            [8'h0C:8'h0F]: fixed_byte = pick(cfg.local_ip, 8'h0F, ptr);
            [8'h1C:8'h21]: fixed_byte = pick(cfg.local_mac, 8'h21, ptr);
            [8'hEC:8'hEF]: fixed_byte = pick(`DHCP_COOKIE, `DHCP_COOKIE_LAST, ptr);
            8'hF0:         fixed_byte = `DHCP_OPT_MSG_TYPE;
            8'hF1:         fixed_byte = 8'd1;
            8'hF2:         fixed_byte = is_new ? `DHCP_MSG_DISCOVER : `DHCP_MSG_REQUEST;
            default:       fixed_byte = 8'h00;
        endcase
    end

    always_comb
    begin
        case (state)
            bld_fixed: msg_data = fixed_byte;
            bld_opt3:  msg_data = opt_byte(`DHCP_OPT_GATEWAY, lease.gateway_ip, ptr);
            bld_opt50: msg_data = opt_byte(`DHCP_OPT_REQ_IP, req_ip, ptr);
            bld_opt54: msg_data = opt_byte(`DHCP_OPT_SERVER_ID, lease.server_id, ptr);
            bld_end:   msg_data = (ptr == 8'd0) ? `DHCP_OPT_END : 8'h00;
            default:   msg_data = 8'h00;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state             <= bld_idle;
            ptr               <= '0;
            discover_finished <= 1'b0;
        end
        else
        begin
            case (state)
                bld_idle:
                begin
                    if (discover_start)
                    begin
                        ptr   <= '0;
                        state <= bld_fixed;
                    end
                end
                bld_done:
                begin
                    if (!discover_start)
                    begin
                        discover_finished <= 1'b0;
                        state             <= bld_idle;
                    end
                end
                default:
                begin
                    if (xfer && ptr != sec_last)
                        ptr <= ptr + 8'd1;
                    else if (xfer)
                    begin
                        ptr <= '0;
                        case (state)
                            bld_fixed: state <= use_gw ? bld_opt3 : bld_opt50;
                            bld_opt3:  state <= bld_opt50;
                            bld_opt50: state <= use_sid ? bld_opt54 : bld_end;
                            bld_opt54: state <= bld_end;
                            default:
                            begin
                                discover_finished <= 1'b1;
                                state             <= bld_done;
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    // message contents are frozen when the message starts
    always_ff @(posedge clk)
    begin
        if (state == bld_idle && discover_start)
        begin
            is_new  <= discover_is_new;
            use_gw  <= !discover_is_new && lease.gateway_valid;
            use_sid <= !discover_is_new && lease.server_id_valid;
            req_ip  <= discover_is_new ? cfg.local_ip : lease.offered_ip;
            if (discover_is_new)
                lease.xid <= xid_seed;
        end
    end

    a_stall_stable: assert property (@(posedge clk) disable iff (rst)
        msg_valid && !msg_ready |=> msg_valid && $stable(msg_data));

    // the byte with last closes the message
    a_last_ends_msg: assert property (@(posedge clk) disable iff (rst)
        msg_last && msg_ready |=> discover_finished && !msg_valid);

endmodule

`default_nettype wire

// ==== logic/dhcp_helper.sv ====
`default_nettype none

module dhcp_helper
    import dhcp_pkg::*;
(
    input  wire        clk,
    input  wire        rst,

    input  wire        eeprom_start,
    output logic       eeprom_finished,
    input  wire byte_t eeprom_data,
    input  wire        eeprom_valid,
    output logic       eeprom_ready,

    input  wire        discover_start,
    input  wire        discover_is_new,
    output logic       discover_finished,
    input  wire xid_t  xid_seed,
    output byte_t      msg_data,
    output logic       msg_valid,
    input  wire        msg_ready,
    output logic       msg_last,

    input  wire        offer_start,
    output logic       offer_finished,
    input  wire byte_t offer_data,
    input  wire        offer_valid,
    output logic       offer_ready,
    input  wire        offer_last,
    output logic       offer_received,

    output mac_addr_t  local_mac,
    output ip_addr_t   local_ip,
    output ip_addr_t   gateway_ip,
    output ip_addr_t   subnet_mask
);

    net_cfg_if cfg ();
    lease_if   lease ();

    assign local_mac   = cfg.local_mac;
    assign local_ip    = cfg.local_ip;
    assign gateway_ip  = cfg.gateway_ip;
    assign subnet_mask = cfg.subnet_mask;

    eeprom_cfg_loader u_loader (
        .clk             (clk),
        .rst             (rst),
        .eeprom_start    (eeprom_start),
        .eeprom_finished (eeprom_finished),
        .eeprom_data     (eeprom_data),
        .eeprom_valid    (eeprom_valid),
        .eeprom_ready    (eeprom_ready),
        .cfg             (cfg)
    );

    offer_parser u_parser (
        .clk            (clk),
        .rst            (rst),
        .offer_start    (offer_start),
        .offer_finished (offer_finished),
        .offer_received (offer_received),
        .offer_data     (offer_data),
        .offer_valid    (offer_valid),
        .offer_ready    (offer_ready),
        .offer_last     (offer_last),
        .lease          (lease)
    );

    discover_builder u_builder (
        .clk               (clk),
        .rst               (rst),
        .discover_start    (discover_start),
        .discover_is_new   (discover_is_new),
        .discover_finished (discover_finished),
        .xid_seed          (xid_seed),
        .msg_data          (msg_data),
        .msg_valid         (msg_valid),
        .msg_ready         (msg_ready),
        .msg_last          (msg_last),
        .cfg               (cfg),
        .lease             (lease)
    );

endmodule

`default_nettype wire

// ==== verification/tb_dhcp_helper.sv ====
`default_nettype none

`include "dhcp_consts.svh"

module tb_dhcp_helper
    import dhcp_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // eeprom record, discover, four offers and four requests
    localparam int num_msgs    = 10;
    localparam int cycle_limit = num_msgs * 300 + 2000;

    logic      clk;
    logic      rst;
    logic      eeprom_start;
    logic      eeprom_finished;
    byte_t     eeprom_data;
    logic      eeprom_valid;
    logic      eeprom_ready;
    logic      discover_start;
    logic      discover_is_new;
    logic      discover_finished;
    xid_t      xid_seed;
    byte_t     msg_data;
    logic      msg_valid;
    logic      msg_ready;
    logic      msg_last;
    logic      offer_start;
    logic      offer_finished;
    byte_t     offer_data;
    logic      offer_valid;
    logic      offer_ready;
    logic      offer_last;
    logic      offer_received;
    mac_addr_t local_mac;
    ip_addr_t  local_ip;
    ip_addr_t  gateway_ip;
    ip_addr_t  subnet_mask;

    integer seed;
    int     cycles = 0;
    int     mismatch_count = 0;
    int     fail_count = 0;
    byte_t  tx_q[$];
    byte_t  exp_q[$];
    byte_t  got_q[$];

    // reference model state
    mac_addr_t m_mac;
    ip_addr_t  m_ip;
    ip_addr_t  m_gw_cfg;
    ip_addr_t  m_mask;
    xid_t      m_xid;
    ip_addr_t  m_offered;
    ip_addr_t  m_gw;
    ip_addr_t  m_sid;
    logic      m_gw_valid;
    logic      m_sid_valid;
    logic      m_received;

    dhcp_helper uut (.*);

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: run did not complete within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic byte_t rand_byte();
        return byte_t'($random(seed));
    endfunction

    // mostly high, for valid gaps and back-pressure
    function automatic bit chance();
        return ($random(seed) & 7) != 0;
    endfunction

    function automatic bit coin();
        return ($random(seed) & 1) == 1;
    endfunction

    task automatic check_word(input string what, input logic [47:0] got,
                              input logic [47:0] exp);
        assert (got === exp)
        else
        begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        assert (cond)
        else
        begin
            fail_count++;
            $display("ERROR at %0t: %s", $time, msg);
        end
    endtask

    // pushes tx_q into the eeprom or the offer stream
    task automatic send_stream(input bit to_offer);
        int sent;
        bit hold;
        bit v;
        bit rdy;
        sent = 0;
        hold = 1'b0;
        while (sent < tx_q.size())
        begin
            @(negedge clk);
            v = hold || chance();
            if (to_offer)
            begin
                offer_valid = v;
                offer_data  = tx_q[sent];
                offer_last  = v && (sent == tx_q.size() - 1);
                rdy         = offer_ready;
            end
            else
            begin
                eeprom_valid = v;
                eeprom_data  = tx_q[sent];
                rdy          = eeprom_ready;
            end
            // a byte offered but not taken stays on the bus
            hold = v && !rdy;
            if (v && rdy)
                sent++;
        end
        @(negedge clk);
        offer_valid  = 1'b0;
        offer_last   = 1'b0;
        eeprom_valid = 1'b0;
    endtask

    task automatic load_eeprom();
        int i;
        tx_q.delete();
        for (i = 0; i < `EEPROM_CFG_BYTES; i++)
            tx_q.push_back(rand_byte());
        m_mac    = {tx_q[0], tx_q[1], tx_q[2], tx_q[3], tx_q[4], tx_q[5]};
        m_ip     = {tx_q[6], tx_q[7], tx_q[8], tx_q[9]};
        m_gw_cfg = {tx_q[10], tx_q[11], tx_q[12], tx_q[13]};
        m_mask   = {tx_q[14], tx_q[15], tx_q[16], tx_q[17]};
        @(negedge clk);
        eeprom_start = 1'b1;
        send_stream(1'b0);
        while (!eeprom_finished)
            @(negedge clk);
        check_true(!eeprom_ready, "eeprom_ready still high after the record");
        check_word("local_mac", local_mac, m_mac);
        check_word("local_ip", local_ip, m_ip);
        check_word("gateway_ip", gateway_ip, m_gw_cfg);
        check_word("subnet_mask", subnet_mask, m_mask);
        eeprom_start = 1'b0;
        @(negedge clk);
        while (eeprom_finished)
            @(negedge clk);
    endtask

    task automatic push_addr_option(ref byte_t q[$], input byte_t id, input ip_addr_t value);
        int i;
        q.push_back(id);
        q.push_back(8'd4);
        for (i = 0; i < 4; i++)
            q.push_back(value[31 - 8 * i -: 8]);
    endtask

    // unknown option, the parser has to skip it
    task automatic push_extra_option();
        int len;
        int i;
        tx_q.push_back(8'd60 + (rand_byte() & 8'h0F));
        len = 1 + (rand_byte() & 8'h03);
        tx_q.push_back(byte_t'(len));
        for (i = 0; i < len; i++)
            tx_q.push_back(rand_byte());
    endtask

    task automatic make_offer(input byte_t op, input xid_t xid, input byte_t msg_type);
        byte_t    order [3];
        byte_t    tmp;
        ip_addr_t cookie;
        int       i;
        int       j;
        tx_q.delete();
        cookie = `DHCP_COOKIE;
        // random filler also gives a random yiaddr
        for (i = 0; i <= `DHCP_COOKIE_LAST; i++)
            tx_q.push_back(rand_byte());
        tx_q[0] = op;
        tx_q[1] = `DHCP_HTYPE_ETH;
        tx_q[2] = `DHCP_HLEN_ETH;
        for (i = 0; i < 4; i++)
        begin
            tx_q[4 + i]   = xid[31 - 8 * i -: 8];
            tx_q[236 + i] = cookie[31 - 8 * i -: 8];
        end
        order[0] = `DHCP_OPT_MSG_TYPE;
        order[1] = `DHCP_OPT_GATEWAY;
        order[2] = `DHCP_OPT_SERVER_ID;
        for (i = 2; i > 0; i--)
        begin
            j        = {$random(seed)} % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (i = 0; i < 3; i++)
        begin
            if (coin())
                push_extra_option();
            if (order[i] == `DHCP_OPT_MSG_TYPE)
            begin
                tx_q.push_back(`DHCP_OPT_MSG_TYPE);
                tx_q.push_back(8'd1);
                tx_q.push_back(msg_type);
            end
            else
                push_addr_option(tx_q, order[i], {rand_byte(), rand_byte(), rand_byte(), rand_byte()});
        end
        tx_q.push_back(`DHCP_OPT_END);
        // trailing bytes after the end option are discarded
        j = rand_byte() & 8'h03;
        for (i = 0; i < j; i++)
            tx_q.push_back(rand_byte());
    endtask

    // applies the parse rules to the frame in tx_q
    task automatic model_offer();
        int    pos;
        int    len;
        byte_t id;
        m_gw_valid  = 1'b0;
        m_sid_valid = 1'b0;
        if (tx_q[0] != `DHCP_OP_BOOTREPLY || tx_q[1] != `DHCP_HTYPE_ETH ||
            tx_q[2] != `DHCP_HLEN_ETH || {tx_q[4], tx_q[5], tx_q[6], tx_q[7]} != m_xid)
            return;
        m_offered = {tx_q[16], tx_q[17], tx_q[18], tx_q[19]};
        pos = `DHCP_COOKIE_LAST + 1;
        while (pos + 1 < tx_q.size())
        begin
            id = tx_q[pos];
            if (id == `DHCP_OPT_END)
                break;
            len = tx_q[pos + 1];
            if (len == 0)
                break;
            pos = pos + 2 + len;
            if (pos > tx_q.size())
                break;
            if (id == `DHCP_OPT_GATEWAY)
            begin
                m_gw       = {tx_q[pos - 4], tx_q[pos - 3], tx_q[pos - 2], tx_q[pos - 1]};
                m_gw_valid = 1'b1;
            end
            else if (id == `DHCP_OPT_SERVER_ID)
            begin
                m_sid       = {tx_q[pos - 4], tx_q[pos - 3], tx_q[pos - 2], tx_q[pos - 1]};
                m_sid_valid = 1'b1;
            end
            else if (id == `DHCP_OPT_MSG_TYPE)
                m_received = (tx_q[pos - 1] == `DHCP_MSG_OFFER);
        end
    endtask

    task automatic run_offer();
        model_offer();
        @(negedge clk);
        offer_start = 1'b1;
        send_stream(1'b1);
        while (!offer_finished)
            @(negedge clk);
        check_true(!offer_ready, "offer_ready still high after tlast");
        offer_start = 1'b0;
        @(negedge clk);
        while (offer_finished)
            @(negedge clk);
        check_word("offer_received", offer_received, m_received);
    endtask

    task automatic make_expected(input bit is_new);
        ip_addr_t cookie;
        int       i;
        exp_q.delete();
        cookie = `DHCP_COOKIE;
        for (i = 0; i <= `DHCP_HEADER_LAST; i++)
            exp_q.push_back(8'h00);
        exp_q[0] = `DHCP_OP_BOOTREQUEST;
        exp_q[1] = `DHCP_HTYPE_ETH;
        exp_q[2] = `DHCP_HLEN_ETH;
        for (i = 0; i < 4; i++)
        begin
            exp_q[4 + i]   = m_xid[31 - 8 * i -: 8];
            exp_q[12 + i]  = m_ip[31 - 8 * i -: 8];
            exp_q[236 + i] = cookie[31 - 8 * i -: 8];
        end
        for (i = 0; i < 6; i++)
            exp_q[28 + i] = m_mac[47 - 8 * i -: 8];
        exp_q[240] = `DHCP_OPT_MSG_TYPE;
        exp_q[241] = 8'd1;
        exp_q[242] = is_new ? `DHCP_MSG_DISCOVER : `DHCP_MSG_REQUEST;
        if (!is_new && m_gw_valid)
            push_addr_option(exp_q, `DHCP_OPT_GATEWAY, m_gw);
        push_addr_option(exp_q, `DHCP_OPT_REQ_IP, is_new ? m_ip : m_offered);
        if (!is_new && m_sid_valid)
            push_addr_option(exp_q, `DHCP_OPT_SERVER_ID, m_sid);
        exp_q.push_back(`DHCP_OPT_END);
        for (i = 0; i < `DHCP_END_PAD; i++)
            exp_q.push_back(8'h00);
    endtask

    task automatic run_message(input bit is_new);
        string name;
        bit    done;
        int    i;
        name = is_new ? "DISCOVER" : "REQUEST";
        @(negedge clk);
        xid_seed = $random(seed);
        if (is_new)
            m_xid = xid_seed;
        make_expected(is_new);
        got_q.delete();
        discover_is_new = is_new;
        discover_start  = 1'b1;
        done = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            msg_ready = chance();
            if (msg_valid && msg_ready)
            begin
                got_q.push_back(msg_data);
                if (msg_last)
                    done = 1'b1;
                else if (got_q.size() > exp_q.size())
                begin
                    check_true(1'b0, {name, " runs past its length without last"});
                    done = 1'b1;
                end
            end
        end
        @(negedge clk);
        msg_ready = 1'b0;
        while (!discover_finished)
            @(negedge clk);
        discover_start = 1'b0;
        @(negedge clk);
        while (discover_finished)
            @(negedge clk);
        if (is_new)
            check_word("DISCOVER length", got_q.size(), 254);
        check_word({name, " length"}, got_q.size(), exp_q.size());
        for (i = 0; i < got_q.size() && i < exp_q.size(); i++)
            check_word($sformatf("%s byte %0d", name, i), got_q[i], exp_q[i]);
    endtask

    initial
    begin
        seed            = 34141;
        rst             = 1'b1;
        eeprom_start    = 1'b0;
        eeprom_data     = 8'h00;
        eeprom_valid    = 1'b0;
        discover_start  = 1'b0;
        discover_is_new = 1'b0;
        xid_seed        = '0;
        msg_ready       = 1'b0;
        offer_start     = 1'b0;
        offer_data      = 8'h00;
        offer_valid     = 1'b0;
        offer_last      = 1'b0;
        m_gw_valid      = 1'b0;
        m_sid_valid     = 1'b0;
        m_received      = 1'b0;
        repeat (8)
            @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        load_eeprom();
        run_message(1'b1);

        // good offer, then a request with gateway and server id
        make_offer(`DHCP_OP_BOOTREPLY, m_xid, `DHCP_MSG_OFFER);
        run_offer();
        run_message(1'b0);

        // foreign xid
        make_offer(`DHCP_OP_BOOTREPLY, m_xid ^ (xid_t'($random(seed)) | 32'd1), `DHCP_MSG_OFFER);
        run_offer();
        run_message(1'b0);

        // wrong op code
        make_offer(`DHCP_OP_BOOTREQUEST, m_xid, `DHCP_MSG_OFFER);
        run_offer();
        run_message(1'b0);

        // type 5 is an ack, not an offer
        make_offer(`DHCP_OP_BOOTREPLY, m_xid, 8'd5);
        run_offer();
        run_message(1'b0);

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
logic/dhcp_pkg.sv
logic/net_cfg_if.sv
logic/lease_if.sv
logic/eeprom_cfg_loader.sv
logic/offer_parser.sv
logic/discover_builder.sv
logic/dhcp_helper.sv
verification/tb_dhcp_helper.sv
